// File: design/map_pkg.sv
// Only regions 0, 2 and 4 are mapped and every other region code is treated as unmapped
package map_pkg;

  //------------------------------
  // Field widths
  //------------------------------
  localparam int region_w = 4;   // Upper nibble selects the region
  localparam int offset_w = 12;  // Lower bits index inside a region

  //------------------------------
  // Region codes
  //------------------------------
  // 0XXX constants, read returns the offset
  // 2XXX register IO, passed to external ports
  // 4XXX general purpose RAM
  // Any other code reads zero and drops writes
  typedef enum logic [region_w-1:0] {
    region_const = 4'h0,  // Constant source
    region_reg   = 4'h2,  // Register IO
    region_ram   = 4'h4   // Scratch RAM
  } region_t;

  // System address, region above offset
  typedef struct packed {
    region_t               region;  // Bits 15:12
    logic [offset_w-1:0]   offset;  // Bits 11:0
  } addr_t;

endpackage

// File: design/bus_pkg.sv
// Request strobes are single-cycle pulses and the address must be held until the response
package bus_pkg;

  //------------------------------
  // Data word
  //------------------------------
  localparam int data_w = 36;  // Full system word

  typedef logic [data_w-1:0] data_t;

  //------------------------------
  // Net transaction
  //------------------------------
  // Source in upper half, target in lower half
  typedef struct packed {
    map_pkg::addr_t  src;  // Read from here
    map_pkg::addr_t  trg;  // Write to here
  } net_t;

  //------------------------------
  // Request buses
  //------------------------------
  // Read request, 17 bits
  typedef struct packed {
    logic            strb;  // One-cycle pulse
    map_pkg::addr_t  addr;  // Held until ready
  } rd_req_t;

  // Write request, 53 bits
  typedef struct packed {
    logic            strb;  // One-cycle pulse
    map_pkg::addr_t  addr;  // Held until done
    data_t           data;  // Held until done
  } wr_req_t;

endpackage

// File: design/net_sequencer.sv
// A net_strb that arrives while a net is in progress is dropped and only one request is ever open
`timescale 1ns/100ps

module net_sequencer
(
  input  logic              clk,            // System clock
  input  logic              reset,          // Synchronous, active high
  input  bus_pkg::net_t     net,            // Source and target pair
  input  logic              net_strb,       // Start a net
  output logic              net_done_strb,  // Net finished
  output bus_pkg::rd_req_t  src_req,        // Source read request
  input  bus_pkg::data_t    src_data,       // Source read data
  input  logic              src_rdy_strb,   // Source data valid
  output bus_pkg::wr_req_t  trg_req,        // Target write request
  input  logic              trg_done_strb   // Target write complete
);

  //------------------------------
  // State
  //------------------------------
  typedef enum logic [1:0] {
    idle,       // Waiting for net_strb
    reading,    // Source read open
    writing,    // Target write open
    finishing   // Done pulse cycle
  } state_t;

  state_t          state;
  logic            rd_strb;  // Read strobe flop
  logic            wr_strb;  // Write strobe flop
  bus_pkg::net_t   net_q;    // Accepted net
  bus_pkg::data_t  data_q;   // Captured source word

  //------------------------------
  // Control FSM
  //------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state   <= idle;
      rd_strb <= 1'b0;
      wr_strb <= 1'b0;
    end
    else
    begin
      rd_strb <= 1'b0;  // Strobes default low
      wr_strb <= 1'b0;
      case (state)
        idle:
        begin
          if (net_strb)
          begin
            state   <= reading;
            rd_strb <= 1'b1;  // Read pulses next cycle
          end
        end
        reading:
        begin
          if (src_rdy_strb)
          begin
            state   <= writing;
            wr_strb <= 1'b1;  // Write right after ready
          end
        end
        writing:
        begin
          if (trg_done_strb)
            state <= finishing;
        end
        finishing:
          state <= idle;  // One cycle of done
        default:
          state <= idle;
      endcase
    end
  end

  // Payload capture
  always_ff @(posedge clk)
  begin
    if (state == idle && net_strb)
      net_q <= net;       // Latch on acceptance
    if (state == reading && src_rdy_strb)
      data_q <= src_data; // Latch on ready
  end

  //------------------------------
  // Outputs
  //------------------------------
  // Addresses come straight from the latched net, so they stay put until the response
  assign src_req.strb = rd_strb;
  assign src_req.addr = net_q.src;

  assign trg_req.strb = wr_strb;
  assign trg_req.addr = net_q.trg;
  assign trg_req.data = data_q;  // Word read from source

  assign net_done_strb = (state == finishing);

endmodule

// File: design/access_router.sv
// Register IO and RAM pass through combinationally while constant and unmapped regions answer after one cycle
`timescale 1ns/100ps

module access_router
#(
  parameter int ram_addr_width = 9  // RAM index bits
)
(
  input  logic              clk,               // System clock
  input  logic              reset,             // Synchronous, active high
  input  bus_pkg::rd_req_t  src_req,           // From sequencer
  output bus_pkg::data_t    src_data,          // Steered read data
  output logic              src_rdy_strb,      // Merged ready
  input  bus_pkg::wr_req_t  trg_req,           // From sequencer
  output logic              trg_done_strb,     // Merged done
  output bus_pkg::rd_req_t  reg_rd_req,        // Register IO read
  input  bus_pkg::data_t    reg_rd_data,
  input  logic              reg_rd_rdy_strb,
  output bus_pkg::wr_req_t  reg_wr_req,        // Register IO write
  input  logic              reg_wr_done_strb,
  output bus_pkg::rd_req_t  ram_rd_req,        // Scratch RAM read
  input  bus_pkg::data_t    ram_rd_data,
  input  logic              ram_rdy_strb,
  output bus_pkg::wr_req_t  ram_wr_req,        // Scratch RAM write
  input  logic              ram_done_strb
);

  // Keeps only the offset bits the RAM decodes
  localparam logic [map_pkg::offset_w-1:0] ram_mask =
    {map_pkg::offset_w{1'b1}} >> (map_pkg::offset_w - ram_addr_width);

  // One-hot destination select
  typedef struct packed {
    logic con;     // Constants
    logic reg_io;  // Register IO
    logic ram;     // Scratch RAM
    logic none;    // Unmapped
  } dest_t;

  dest_t src_dest;
  dest_t trg_dest;
  logic  con_rdy_q, con_done_q;    // Constant response flops
  logic  none_rdy_q, none_done_q;  // Unmapped response flops

  //------------------------------
  // Region decode
  //------------------------------
  function automatic dest_t decode(input logic strb, input map_pkg::region_t region);
    dest_t d;
    d = '0;
    case (region)
      map_pkg::region_const: d.con    = strb;
      map_pkg::region_reg:   d.reg_io = strb;
      map_pkg::region_ram:   d.ram    = strb;
      default:               d.none   = strb;  // Anything else
    endcase
    return d;
  endfunction

  assign src_dest = decode(src_req.strb, src_req.addr.region);
  assign trg_dest = decode(trg_req.strb, trg_req.addr.region);

  // Request steering
  always_comb
  begin
    reg_rd_req      = src_req;
    reg_rd_req.strb = src_dest.reg_io;
    reg_wr_req      = trg_req;
    reg_wr_req.strb = trg_dest.reg_io;

    ram_rd_req             = src_req;
    ram_rd_req.strb        = src_dest.ram;
    ram_rd_req.addr.offset = src_req.addr.offset & ram_mask;  // Trim to RAM depth
    ram_wr_req             = trg_req;
    ram_wr_req.strb        = trg_dest.ram;
    ram_wr_req.addr.offset = trg_req.addr.offset & ram_mask;
  end

  //------------------------------
  // Local responders
  //------------------------------
  // Constant writes are no-ops and unmapped writes are dropped, both still complete
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      con_rdy_q   <= 1'b0;
      con_done_q  <= 1'b0;
      none_rdy_q  <= 1'b0;
      none_done_q <= 1'b0;
    end
    else
    begin
      con_rdy_q   <= src_dest.con;
      con_done_q  <= trg_dest.con;
      none_rdy_q  <= src_dest.none;
      none_done_q <= trg_dest.none;
    end
  end

  // Read data follows the held source region
  always_comb
  begin
    case (src_req.addr.region)
      map_pkg::region_const: src_data = bus_pkg::data_t'(src_req.addr.offset);  // Zero-extend
      map_pkg::region_reg:   src_data = reg_rd_data;
      map_pkg::region_ram:   src_data = ram_rd_data;
      default:               src_data = '0;  // Unmapped reads zero
    endcase
  end

  // Response merge
  assign src_rdy_strb  = con_rdy_q | none_rdy_q | reg_rd_rdy_strb | ram_rdy_strb;
  assign trg_done_strb = con_done_q | none_done_q | reg_wr_done_strb | ram_done_strb;

endmodule

// File: design/scratch_ram.sv
// Contents are undefined until written and the read address must stay steady until ready
`timescale 1ns/100ps

module scratch_ram
#(
  parameter int ram_addr_width = 9  // 2^width words
)
(
  input  logic              clk,        // System clock
  input  logic              reset,      // Clears strobe pipes only
  input  bus_pkg::rd_req_t  rd_req,     // Read strobe and address
  output bus_pkg::data_t    rd_data,    // Registered read word
  output logic              rdy_strb,   // Two cycles after read strobe
  input  bus_pkg::wr_req_t  wr_req,     // Write strobe, address, data
  output logic              done_strb   // Two cycles after write strobe
);

  localparam int depth = 2 ** ram_addr_width;

  bus_pkg::data_t             mem [depth];  // Block RAM array
  logic [ram_addr_width-1:0]  rd_idx;
  logic [ram_addr_width-1:0]  wr_idx;
  logic [1:0]                 rd_pipe;      // Read strobe delay
  logic [1:0]                 wr_pipe;      // Write strobe delay

  // Low offset bits index the array
  assign rd_idx = rd_req.addr.offset[ram_addr_width-1:0];
  assign wr_idx = wr_req.addr.offset[ram_addr_width-1:0];

  //------------------------------
  // Memory
  //------------------------------
  always_ff @(posedge clk)
  begin
    if (wr_req.strb)
      mem[wr_idx] <= wr_req.data;
    rd_data <= mem[rd_idx];  // Re-read every cycle, valid while address held
  end

  //------------------------------
  // Strobe pipelines
  //------------------------------
  // Shift registers, so several strobes may be in flight
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rd_pipe <= '0;
      wr_pipe <= '0;
    end
    else
    begin
      rd_pipe <= {rd_pipe[0], rd_req.strb};
      wr_pipe <= {wr_pipe[0], wr_req.strb};
    end
  end

  assign rdy_strb  = rd_pipe[1];
  assign done_strb = wr_pipe[1];

endmodule

// File: design/sequence_mapping.sv
// Register IO must answer every request strobe with exactly one ready or done pulse after one or more cycles
`timescale 1ns/100ps

module sequence_mapping
#(
  parameter int ram_addr_width = 9  // Scratch RAM index bits
)
(
  input  logic              clk,               // System clock
  input  logic              reset,             // Synchronous, active high
  input  bus_pkg::net_t     net,               // Source and target pair
  input  logic              net_strb,          // Start a net
  output logic              net_done_strb,     // Net finished
  output bus_pkg::rd_req_t  reg_rd_req,        // Register IO read
  input  bus_pkg::data_t    reg_rd_data,       // Register read word
  input  logic              reg_rd_rdy_strb,   // Register read ready
  output bus_pkg::wr_req_t  reg_wr_req,        // Register IO write
  input  logic              reg_wr_done_strb   // Register write done
);

  //------------------------------
  // Internal buses
  //------------------------------
  bus_pkg::rd_req_t  src_req;        // Sequencer to router
  bus_pkg::data_t    src_data;
  logic              src_rdy_strb;
  bus_pkg::wr_req_t  trg_req;
  logic              trg_done_strb;

  bus_pkg::rd_req_t  ram_rd_req;     // Router to RAM
  bus_pkg::data_t    ram_rd_data;
  logic              ram_rdy_strb;
  bus_pkg::wr_req_t  ram_wr_req;
  logic              ram_done_strb;

  // Net into one read and one write
  net_sequencer i_net_sequencer (
    .clk           (clk),
    .reset         (reset),
    .net           (net),
    .net_strb      (net_strb),
    .net_done_strb (net_done_strb),
    .src_req       (src_req),
    .src_data      (src_data),
    .src_rdy_strb  (src_rdy_strb),
    .trg_req       (trg_req),
    .trg_done_strb (trg_done_strb)
  );

  // Region decode and response merge
  access_router #(.ram_addr_width(ram_addr_width)) i_access_router (
    .clk              (clk),
    .reset            (reset),
    .src_req          (src_req),
    .src_data         (src_data),
    .src_rdy_strb     (src_rdy_strb),
    .trg_req          (trg_req),
    .trg_done_strb    (trg_done_strb),
    .reg_rd_req       (reg_rd_req),
    .reg_rd_data      (reg_rd_data),
    .reg_rd_rdy_strb  (reg_rd_rdy_strb),
    .reg_wr_req       (reg_wr_req),
    .reg_wr_done_strb (reg_wr_done_strb),
    .ram_rd_req       (ram_rd_req),
    .ram_rd_data      (ram_rd_data),
    .ram_rdy_strb     (ram_rdy_strb),
    .ram_wr_req       (ram_wr_req),
    .ram_done_strb    (ram_done_strb)
  );

  // General purpose storage
  scratch_ram #(.ram_addr_width(ram_addr_width)) i_scratch_ram (
    .clk       (clk),
    .reset     (reset),
    .rd_req    (ram_rd_req),
    .rd_data   (ram_rd_data),
    .rdy_strb  (ram_rdy_strb),
    .wr_req    (ram_wr_req),
    .done_strb (ram_done_strb)
  );

endmodule

// File: verification/sequence_mapping_checker.sv
// Assumes one-cycle request strobes and a synchronous reset, checks only the sequencer side
`timescale 1ns/100ps

module sequence_mapping_checker
(
  input  logic              clk,
  input  logic              reset,
  input  bus_pkg::rd_req_t  src_req,        // Source read request
  input  bus_pkg::wr_req_t  trg_req,        // Target write request
  input  logic              src_rdy_strb,   // Source read answered
  input  logic              net_done_strb   // Net finished
);

  logic rd_open;      // Read issued, ready still pending
  int   assert_errs;  // Assertion failures so far

  always_ff @(posedge clk)
  begin
    if (reset)
      rd_open <= 1'b0;
    else if (src_req.strb)
      rd_open <= 1'b1;
    else if (src_rdy_strb)
      rd_open <= 1'b0;  // Ready closes the read
  end

  // Never a read and a write in the same cycle
  a_no_overlap: assert property (@(posedge clk) disable iff (reset)
    !(src_req.strb && trg_req.strb))
    else
    begin
      assert_errs++;
      $error("read and write strobes high in the same cycle");
    end

  // Done is a single pulse
  a_done_pulse: assert property (@(posedge clk) disable iff (reset)
    net_done_strb |=> !net_done_strb)
    else
    begin
      assert_errs++;
      $error("net_done_strb high for more than one cycle");
    end

  a_one_read: assert property (@(posedge clk) disable iff (reset)
    src_req.strb |-> !rd_open)  // Previous read must be answered
    else
    begin
      assert_errs++;
      $error("new read issued before the previous ready");
    end

endmodule

bind net_sequencer sequence_mapping_checker i_checker (
  .clk           (clk),
  .reset         (reset),
  .src_req       (src_req),
  .trg_req       (trg_req),
  .src_rdy_strb  (src_rdy_strb),
  .net_done_strb (net_done_strb)
);

// File: verification/sequence_mapping_tb.sv
// All offsets stay below the RAM depth and RAM words are only read after a net has written them
`timescale 1ns/100ps

module sequence_mapping_tb;

  localparam int ram_addr_width = 9;
  localparam int ram_words      = 1 << ram_addr_width;
  localparam int planned_nets   = 70;  // Sum of all test loops
  localparam int cycle_limit    = 200 * planned_nets + 100;

  logic              clk;
  logic              reset;
  bus_pkg::net_t     net;
  logic              net_strb;
  logic              net_done_strb;
  bus_pkg::rd_req_t  reg_rd_req;
  bus_pkg::data_t    reg_rd_data;
  logic              reg_rd_rdy_strb;
  bus_pkg::wr_req_t  reg_wr_req;
  logic              reg_wr_done_strb;

  bus_pkg::data_t    reg_mem [4096];        // Register responder storage
  bus_pkg::data_t    reg_model [4096];      // Expected register contents
  bus_pkg::data_t    ram_model [ram_words]; // Expected RAM contents
  logic [11:0]       ram_used [$];          // RAM offsets written so far
  map_pkg::addr_t    last_rd_addr;
  map_pkg::addr_t    last_wr_addr;
  bus_pkg::data_t    last_wr_data;
  int                rd_cnt, wr_cnt;        // Reg request strobes seen
  int                done_cnt, nets_sent, cycle_cnt;
  int                addr_errs, data_errs, count_errs;

  sequence_mapping #(.ram_addr_width(ram_addr_width)) i_dut (.*);

  //------------------------------
  // Clock, timeout, done count
  //------------------------------
  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial
  begin
    while (cycle_cnt < cycle_limit)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, a net never completed", cycle_cnt);
    $display("TESTS FAILED");
    $finish;
  end

  always @(negedge clk)
    if (net_done_strb === 1'b1)
      done_cnt++;

  // Every cycle of a request strobe counts, also while the responder waits
  always @(negedge clk)
  begin
    if (reg_rd_req.strb === 1'b1)
      rd_cnt++;
    if (reg_wr_req.strb === 1'b1)
      wr_cnt++;
  end

  //------------------------------
  // Register IO responder
  //------------------------------
  initial
  begin
    reg_rd_data      = '0;
    reg_rd_rdy_strb  = 1'b0;
    reg_wr_done_strb = 1'b0;
    for (int i = 0; i < 4096; i++)
      reg_mem[i] = bus_pkg::data_t'(i) + 36'h100000000;
    forever
    begin
      @(negedge clk);
      reg_rd_rdy_strb  = 1'b0;  // Responses last one cycle
      reg_wr_done_strb = 1'b0;
      if (reg_rd_req.strb === 1'b1)
      begin
        last_rd_addr = reg_rd_req.addr;
        repeat (1 + $urandom % 5) @(negedge clk);  // 1 to 5 cycles
        reg_rd_data     = reg_mem[last_rd_addr.offset];
        reg_rd_rdy_strb = 1'b1;
      end
      else if (reg_wr_req.strb === 1'b1)
      begin
        last_wr_addr = reg_wr_req.addr;
        last_wr_data = reg_wr_req.data;
        reg_mem[last_wr_addr.offset] = last_wr_data;
        repeat (1 + $urandom % 5) @(negedge clk);
        reg_wr_done_strb = 1'b1;
      end
    end
  end

  //------------------------------
  // Reference model
  //------------------------------
  function automatic bus_pkg::data_t model_read(input map_pkg::addr_t a);
    case (a.region)
      map_pkg::region_const: return bus_pkg::data_t'(a.offset);  // Offset zero-extended
      map_pkg::region_reg:   return reg_model[a.offset];
      map_pkg::region_ram:   return ram_model[a.offset[ram_addr_width-1:0]];
      default:               return '0;  // Unmapped reads zero
    endcase
  endfunction

  function automatic void model_write(input map_pkg::addr_t a, input bus_pkg::data_t d);
    case (a.region)
      map_pkg::region_reg: reg_model[a.offset] = d;
      map_pkg::region_ram:
      begin
        ram_model[a.offset[ram_addr_width-1:0]] = d;
        ram_used.push_back(a.offset);
      end
      default: ;  // Constant and unmapped targets keep nothing
    endcase
  endfunction

  // Random address inside the RAM depth
  function automatic map_pkg::addr_t pick_addr(input logic [3:0] region);
    return map_pkg::addr_t'({region, 12'($urandom % ram_words)});
  endfunction

  function automatic map_pkg::addr_t ram_src();
    return map_pkg::addr_t'({4'h4, ram_used[$urandom % ram_used.size()]});
  endfunction

  function automatic logic [3:0] unmapped_region();
    logic [3:0] r;
    r = 4'($urandom % 16);
    while (r == 4'h0 || r == 4'h2 || r == 4'h4)
      r = 4'($urandom % 16);
    return r;
  endfunction

  //------------------------------
  // Compare tasks
  //------------------------------
  task automatic check_addr(input string name, input map_pkg::addr_t exp,
                            input map_pkg::addr_t act);
    if (act !== exp)
    begin
      addr_errs++;
      $display("Error: %s expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic check_data(input string name, input bus_pkg::data_t exp,
                            input bus_pkg::data_t act);
    if (act !== exp)
    begin
      data_errs++;
      $display("Error: %s expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act !== exp)
    begin
      count_errs++;
      $display("Error: %s expected %h, got %h", name, exp, act);
    end
  endtask

  // One net, optionally with extra net_strb pulses while busy
  task automatic run_net(input map_pkg::addr_t src, input map_pkg::addr_t trg, input bit noisy);
    bus_pkg::data_t exp;
    int             rd0;
    int             wr0;
    exp = model_read(src);
    rd0 = rd_cnt;
    wr0 = wr_cnt;
    @(negedge clk);  // Sequencer back in idle
    net      = {src, trg};
    net_strb = 1'b1;
    do
    begin
      @(negedge clk);
      net_strb = noisy ? 1'($urandom % 2) : 1'b0;  // Must be ignored
      if (noisy)
        net = bus_pkg::net_t'($urandom);
    end
    while (net_done_strb !== 1'b1);
    net_strb = 1'b0;
    nets_sent++;
    if (src.region == map_pkg::region_reg)
    begin
      check_count("reg_rd_req.strb pulses", rd0 + 1, rd_cnt);
      check_addr("reg_rd_req.addr", src, last_rd_addr);
    end
    else
      check_count("reg_rd_req.strb pulses", rd0, rd_cnt);
    if (trg.region == map_pkg::region_reg)
    begin
      check_count("reg_wr_req.strb pulses", wr0 + 1, wr_cnt);
      check_addr("reg_wr_req.addr", trg, last_wr_addr);
      check_data("reg_wr_req.data", exp, last_wr_data);
    end
    else
      check_count("reg_wr_req.strb pulses", wr0, wr_cnt);
    model_write(trg, exp);
  endtask

  //------------------------------
  // Test sequence
  //------------------------------
  initial
  begin : main
    int idle_high;
    int assert_errs;
    void'($urandom(48));
    reset    = 1'b1;
    net      = '0;
    net_strb = 1'b0;
    for (int i = 0; i < 4096; i++)
      reg_model[i] = bus_pkg::data_t'(i) + 36'h100000000;

    // Ten cycles of reset, then idle, no strobe may rise
    for (int c = 0; c < 15; c++)
    begin
      @(negedge clk);
      if (c == 9)
        reset = 1'b0;
      if (net_done_strb !== 1'b0 || reg_rd_req.strb !== 1'b0 || reg_wr_req.strb !== 1'b0)
        idle_high++;
    end
    check_count("strobes high before first net", 0, idle_high);

    repeat (8) run_net(pick_addr(4'h0), pick_addr(4'h2), 1'b0);    // Constant to reg
    repeat (16) run_net(pick_addr(4'h0), pick_addr(4'h4), 1'b0);   // Fill RAM
    repeat (16) run_net(ram_src(), pick_addr(4'h2), 1'b0);         // RAM to reg
    repeat (10) run_net(pick_addr(4'h2), pick_addr(4'h2), 1'b0);   // Reg to reg
    repeat (4) run_net(pick_addr(unmapped_region()), pick_addr(4'h2), 1'b0);
    repeat (4) run_net(pick_addr(4'h0), pick_addr(unmapped_region()), 1'b0);

    // Mixed nets under extra start pulses
    repeat (12)
    begin
      case ($urandom % 3)
        0:       run_net(pick_addr(4'h0), pick_addr(4'h4), 1'b1);
        1:       run_net(pick_addr(4'h2), pick_addr(4'h2), 1'b1);
        default: run_net(ram_src(), pick_addr(4'h2), 1'b1);
      endcase
    end

    @(negedge clk);
    check_count("net_done_strb pulses", nets_sent, done_cnt);
    assert_errs = i_dut.i_net_sequencer.i_checker.assert_errs;  // Bound checker failures
    $display("Errors: address %0d, data %0d, count %0d, assertion %0d",
             addr_errs, data_errs, count_errs, assert_errs);
    if (addr_errs + data_errs + count_errs + assert_errs == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: build.f
design/map_pkg.sv
design/bus_pkg.sv
design/net_sequencer.sv
design/access_router.sv
design/scratch_ram.sv
design/sequence_mapping.sv
verification/sequence_mapping_checker.sv
verification/sequence_mapping_tb.sv

// File: Makefile
# Verilator build and run of the sequence_mapping testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, fail on a failing run"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -f build.f --top-module sequence_mapping_tb -Mdir obj_dir
	./obj_dir/Vsequence_mapping_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
